//--- rtl/game_pkg.sv
package game_pkg;

    // Playfield coordinate, 0 to 511 on both axes
    typedef logic [8:0] coord_t;

    // Enemy hit points
    typedef logic [6:0] hp_t;

    // Facing direction code
    typedef logic [1:0] dir_t;

    // Game ticks spent dead
    typedef logic [6:0] tick_cnt_t;

    // Direction codes as sent by the player controller
    localparam dir_t DIR_DOWN  = 2'd0;
    localparam dir_t DIR_LEFT  = 2'd1;
    localparam dir_t DIR_UP    = 2'd2;
    localparam dir_t DIR_RIGHT = 2'd3;

    // One attack strobe worth of data
    typedef struct packed {
        coord_t player_x;
        coord_t player_y;
        dir_t   dir;
        coord_t enemy_x;
        coord_t enemy_y;
    } attack_req_t;

    // Sprite sizes
    localparam coord_t PLAYER_W = 9'd26;
    localparam coord_t PLAYER_H = 9'd26;
    localparam coord_t ENEMY_W  = 9'd26;
    localparam coord_t ENEMY_H  = 9'd26;

    // Attack box, reach along facing and width across it
    localparam coord_t ATTACK_LEN = 9'd100;
    localparam coord_t ATTACK_WID = 9'd16;

    // Health and respawn
    localparam hp_t       MAX_HP        = 7'd100;
    localparam hp_t       DAMAGE        = 7'd25;
    localparam int        FRAME_DIV     = 4;
    localparam tick_cnt_t RESPAWN_TICKS = 7'd80;

endpackage

//--- rtl/frame_tick.sv
`timescale 1ns/1ps

module frame_tick import game_pkg::*; (
    input  logic Clk,
    input  logic arst_n,
    input  logic frame_clk,
    output logic game_tick
);

    // Synchronizer stages and edge-detect delay
    logic frame_meta;
    logic frame_sync;
    logic frame_dly;
    logic frame_rise;

    // Counts detected frame edges within one game tick
    logic [1:0] div_q;

    // Frame clock is asynchronous to Clk
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_meta <= 1'b0;
            frame_sync <= 1'b0;
            frame_dly  <= 1'b0;
        end else begin
            frame_meta <= frame_clk;
            frame_sync <= frame_meta;
            frame_dly  <= frame_sync;
        end
    end

    // High for one cycle per frame clock rising edge
    assign frame_rise = frame_sync & ~frame_dly;

    // One game tick every FRAME_DIV frame edges
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            div_q     <= 2'd0;
            game_tick <= 1'b0;
        end else begin
            game_tick <= 1'b0;
            if (frame_rise) begin
                if (div_q == 2'(FRAME_DIV - 1)) begin
                    div_q     <= 2'd0;
                    game_tick <= 1'b1;
                end else begin
                    div_q <= div_q + 2'd1;
                end
            end
        end
    end

endmodule

//--- rtl/attack_hit_detect.sv
`timescale 1ns/1ps

module attack_hit_detect import game_pkg::*; (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        attack_valid,
    input  attack_req_t attack_req,
    output logic        hit_valid,
    output logic        hit
);

    // One bit wider so box ends past 511 do not wrap
    logic [9:0] player_x;
    logic [9:0] player_y;
    logic [9:0] enemy_x0;
    logic [9:0] enemy_y0;
    logic [9:0] enemy_x1;
    logic [9:0] enemy_y1;

    // Starts of the boxes reaching back toward zero, clipped
    logic [9:0] left_x0;
    logic [9:0] up_y0;

    // Attack box, end coordinates exclusive
    logic [9:0] box_x0;
    logic [9:0] box_x1;
    logic [9:0] box_y0;
    logic [9:0] box_y1;

    logic overlap;

    assign player_x = {1'b0, attack_req.player_x};
    assign player_y = {1'b0, attack_req.player_y};

    // Enemy box
    assign enemy_x0 = {1'b0, attack_req.enemy_x};
    assign enemy_y0 = {1'b0, attack_req.enemy_y};
    assign enemy_x1 = enemy_x0 + {1'b0, ENEMY_W};
    assign enemy_y1 = enemy_y0 + {1'b0, ENEMY_H};

    // Clip at the playfield edge
    assign left_x0 = (attack_req.player_x < ATTACK_LEN) ? 10'd0
                                                         : player_x - {1'b0, ATTACK_LEN};
    assign up_y0   = (attack_req.player_y < ATTACK_LEN) ? 10'd0
                                                         : player_y - {1'b0, ATTACK_LEN};

    always_comb begin
        box_x0 = 10'd0;
        box_x1 = 10'd0;
        box_y0 = 10'd0;
        box_y1 = 10'd0;
        case (attack_req.dir)
            DIR_DOWN: begin
                // Narrow box below the sprite
                box_x0 = player_x;
                box_x1 = player_x + {1'b0, ATTACK_WID};
                box_y0 = player_y + {1'b0, PLAYER_H};
                box_y1 = box_y0 + {1'b0, ATTACK_LEN};
            end
            DIR_UP: begin
                // Ends at the top edge of the sprite
                box_x0 = player_x;
                box_x1 = player_x + {1'b0, ATTACK_WID};
                box_y0 = up_y0;
                box_y1 = player_y;
            end
            DIR_LEFT: begin
                box_x0 = left_x0;
                box_x1 = player_x;
                box_y0 = player_y;
                box_y1 = player_y + {1'b0, ATTACK_WID};
            end
            DIR_RIGHT: begin
                box_x0 = player_x + {1'b0, PLAYER_W};
                box_x1 = box_x0 + {1'b0, ATTACK_LEN};
                box_y0 = player_y;
                box_y1 = player_y + {1'b0, ATTACK_WID};
            end
            default: begin
            end
        endcase
    end

    // Strict compare on both axes, touching edges miss
    assign overlap = (box_x0 < enemy_x1) && (enemy_x0 < box_x1) &&
                     (box_y0 < enemy_y1) && (enemy_y0 < box_y1);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= attack_valid;
        end
    end

    // Only meaningful while hit_valid is high
    always_ff @(posedge Clk) begin
        hit <= overlap;
    end

endmodule

//--- rtl/enemy_health.sv
`timescale 1ns/1ps

module enemy_health import game_pkg::*; (
    input  logic Clk,
    input  logic arst_n,
    input  logic game_tick,
    input  logic hit_valid,
    input  logic hit,
    output hp_t  enemy_hp,
    output logic enemy_alive
);

    typedef enum logic {
        ST_ALIVE,
        ST_RESPAWN
    } state_t;

    state_t    state_q;
    state_t    state_d;
    hp_t       hp_q;
    hp_t       hp_d;
    tick_cnt_t cnt_q;
    tick_cnt_t cnt_d;
    tick_cnt_t cnt_inc;

    assign cnt_inc = cnt_q + 7'd1;

    always_comb begin
        state_d = state_q;
        hp_d    = hp_q;
        cnt_d   = cnt_q;
        case (state_q)
            ST_ALIVE: begin
                if (hit_valid && hit) begin
                    // Saturate at zero, then start the respawn wait
                    if (hp_q <= DAMAGE) begin
                        hp_d    = '0;
                        cnt_d   = '0;
                        state_d = ST_RESPAWN;
                    end else begin
                        hp_d = hp_q - DAMAGE;
                    end
                end
            end
            ST_RESPAWN: begin
                // Hits are ignored while dead
                if (game_tick) begin
                    cnt_d = cnt_inc;
                    if (cnt_inc == RESPAWN_TICKS) begin
                        hp_d    = MAX_HP;
                        state_d = ST_ALIVE;
                    end
                end
            end
            default: begin
                state_d = ST_ALIVE;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_ALIVE;
            hp_q    <= MAX_HP;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            hp_q    <= hp_d;
            cnt_q   <= cnt_d;
        end
    end

    // State and hit points change on the same edge
    assign enemy_alive = (state_q == ST_ALIVE);
    assign enemy_hp    = hp_q;

endmodule

//--- rtl/game_logic.sv
`timescale 1ns/1ps

module game_logic import game_pkg::*; (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        frame_clk,
    input  logic        attack_valid,
    input  attack_req_t attack_req,
    output logic        hit_valid,
    output logic        hit,
    output hp_t         enemy_hp,
    output logic        enemy_alive
);

    // Slow tick for the respawn timer
    logic game_tick;

    frame_tick u_frame_tick (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .frame_clk (frame_clk),
        .game_tick (game_tick)
    );

    // One register stage from strobe to hit result
    attack_hit_detect u_attack_hit_detect (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .attack_valid (attack_valid),
        .attack_req   (attack_req),
        .hit_valid    (hit_valid),
        .hit          (hit)
    );

    // Hit result also leaves the top level unchanged
    enemy_health u_enemy_health (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .game_tick   (game_tick),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .enemy_hp    (enemy_hp),
        .enemy_alive (enemy_alive)
    );

endmodule

//--- dv/game_logic_checker.sv
`timescale 1ns/1ps

module game_logic_checker import game_pkg::*; (
    input logic Clk,
    input logic arst_n,
    input logic attack_valid,
    input logic hit_valid,
    input hp_t  enemy_hp,
    input logic enemy_alive
);

    // Hit points stay in range
    hp_max: assert property (
        @(posedge Clk) disable iff (!arst_n)
        enemy_hp <= MAX_HP
    ) else $error("enemy_hp above MAX_HP");

    // Dead exactly at zero hit points
    alive_matches_hp: assert property (
        @(posedge Clk) disable iff (!arst_n)
        (!enemy_alive) == (enemy_hp == '0)
    ) else $error("enemy_alive does not match enemy_hp");

    // Each hit result comes from a strobe one cycle earlier
    hit_valid_has_source: assert property (
        @(posedge Clk) disable iff (!arst_n)
        hit_valid |-> $past(attack_valid)
    ) else $error("hit_valid without attack_valid one cycle earlier");

endmodule

bind game_logic game_logic_checker checker0 (
    .Clk          (Clk),
    .arst_n       (arst_n),
    .attack_valid (attack_valid),
    .hit_valid    (hit_valid),
    .enemy_hp     (enemy_hp),
    .enemy_alive  (enemy_alive)
);

//--- dv/tb_game_logic.sv
`timescale 1ns/1ps

module tb_game_logic import game_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    // Clk cycles per frame_clk half period
    localparam int FRAME_HALF = 4;
    localparam int NUM_CYCLES = 8000;
    // One full respawn wait in ns
    localparam int RESPAWN_NS = int'(RESPAWN_TICKS) * FRAME_DIV * 2 * FRAME_HALF * CLK_PERIOD;
    localparam int WATCHDOG_NS = (NUM_CYCLES + 3) * CLK_PERIOD + 3 * RESPAWN_NS;
    // Upper bound on the frame edge to game tick latency
    localparam int SYNC_NS = 4 * CLK_PERIOD;

    logic        Clk;
    logic        arst_n;
    logic        frame_clk;
    logic        attack_valid;
    attack_req_t attack_req;
    logic        hit_valid;
    logic        hit;
    hp_t         enemy_hp;
    logic        enemy_alive;

    // Model state
    logic [31:0] rng;
    logic        hit_q[$];
    logic        pend_valid;
    hp_t         model_hp;
    logic        model_alive;
    int          frame_edges = 0;
    int          dead_ticks = 0;
    int          kills = 0;
    int          respawns = 0;
    // Frame edge of the latest model game tick
    time         last_tick_t = 0;

    game_logic dut0 (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .frame_clk    (frame_clk),
        .attack_valid (attack_valid),
        .attack_req   (attack_req),
        .hit_valid    (hit_valid),
        .hit          (hit),
        .enemy_hp     (enemy_hp),
        .enemy_alive  (enemy_alive)
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // Slow frame clock toggling off the Clk edges
    initial begin
        frame_clk = 1'b0;
        @(posedge arst_n);
        forever begin
            repeat (FRAME_HALF) @(posedge Clk);
            #5;
            frame_clk = ~frame_clk;
        end
    end

    // Model game ticks counted only while dead
    always @(posedge frame_clk) begin
        frame_edges = frame_edges + 1;
        if ((frame_edges % FRAME_DIV) == 0) begin
            last_tick_t = $time;
            if (!model_alive) begin
                dead_ticks = dead_ticks + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the test loop finished");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Attack box against enemy box in signed math so clipping is explicit
    function automatic logic expect_hit(input attack_req_t r);
        int px;
        int py;
        int ex;
        int ey;
        int bx0;
        int bx1;
        int by0;
        int by1;
        px = int'(r.player_x);
        py = int'(r.player_y);
        ex = int'(r.enemy_x);
        ey = int'(r.enemy_y);
        bx0 = 0;
        bx1 = 0;
        by0 = 0;
        by1 = 0;
        case (r.dir)
            DIR_DOWN: begin
                bx0 = px;
                bx1 = px + int'(ATTACK_WID);
                by0 = py + int'(PLAYER_H);
                by1 = by0 + int'(ATTACK_LEN);
            end
            DIR_UP: begin
                bx0 = px;
                bx1 = px + int'(ATTACK_WID);
                by0 = py - int'(ATTACK_LEN);
                by1 = py;
            end
            DIR_LEFT: begin
                bx0 = px - int'(ATTACK_LEN);
                bx1 = px;
                by0 = py;
                by1 = py + int'(ATTACK_WID);
            end
            default: begin
                bx0 = px + int'(PLAYER_W);
                bx1 = bx0 + int'(ATTACK_LEN);
                by0 = py;
                by1 = py + int'(ATTACK_WID);
            end
        endcase
        // Playfield edge
        if (bx0 < 0) begin
            bx0 = 0;
        end
        if (by0 < 0) begin
            by0 = 0;
        end
        return (bx0 < ex + int'(ENEMY_W)) && (ex < bx1) &&
               (by0 < ey + int'(ENEMY_H)) && (ey < by1);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got 0x%0h expected 0x%0h at %0t",
                                     name, got, exp, $time));
        end
    endtask

    task automatic check_hp(input hp_t got, input hp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED enemy_hp: got 0x%0h expected 0x%0h at %0t",
                                     got, exp, $time));
        end
    endtask

    task automatic check_alive(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED enemy_alive: got 0x%0h expected 0x%0h at %0t",
                                     got, exp, $time));
        end
    endtask

    // Compare outputs after one edge and step the model to the next
    task automatic check_outputs();
        logic exp_hit;
        if (!model_alive && enemy_alive) begin
            if (dead_ticks < int'(RESPAWN_TICKS) || dead_ticks > int'(RESPAWN_TICKS) + 1) begin
                report_failure($sformatf("enemy respawned after %0d game ticks, expected %0d",
                                         dead_ticks, RESPAWN_TICKS));
            end
            model_hp    = MAX_HP;
            model_alive = 1'b1;
            respawns    = respawns + 1;
        end
        // Latest allowed respawn already passed
        if (!model_alive && dead_ticks > int'(RESPAWN_TICKS) + 1) begin
            report_failure($sformatf("enemy still dead after %0d game ticks, expected %0d",
                                     dead_ticks, RESPAWN_TICKS));
        end
        check_hp(enemy_hp, model_hp);
        check_alive(enemy_alive, model_alive);
        check_hit("hit_valid", hit_valid, pend_valid);
        if (pend_valid) begin
            exp_hit = hit_q.pop_front();
            check_hit("hit", hit, exp_hit);
            // Damage lands on the next edge and is ignored while dead
            if (exp_hit && model_alive) begin
                if (model_hp <= DAMAGE) begin
                    model_hp    = '0;
                    model_alive = 1'b0;
                    // Tick still in the synchronizer may reach the DUT after death
                    if (frame_edges >= FRAME_DIV && $time - last_tick_t < SYNC_NS) begin
                        dead_ticks = 1;
                    end else begin
                        dead_ticks = 0;
                    end
                    kills       = kills + 1;
                end else begin
                    model_hp = model_hp - DAMAGE;
                end
            end
        end
    endtask

    task automatic drive_attack();
        attack_req_t req;
        logic        near;
        logic        low;
        rng = xorshift32(rng);
        attack_valid = rng[0];
        req.dir = rng[2:1];
        near = rng[3];
        low = (rng[5:4] == 2'b00);
        rng = xorshift32(rng);
        req.player_x = rng[8:0];
        req.player_y = rng[17:9];
        // Close to zero so up and left boxes clip
        if (low) begin
            req.player_x = req.player_x & 9'h07f;
            req.player_y = req.player_y & 9'h07f;
        end
        rng = xorshift32(rng);
        // Enemy within 64 of the player half the time
        if (near) begin
            req.enemy_x = req.player_x + {2'b00, rng[6:0]} - 9'd64;
            req.enemy_y = req.player_y + {2'b00, rng[13:7]} - 9'd64;
        end else begin
            req.enemy_x = rng[8:0];
            req.enemy_y = rng[17:9];
        end
        attack_req = req;
        if (attack_valid) begin
            hit_q.push_back(expect_hit(req));
        end
        pend_valid = attack_valid;
    endtask

    initial begin
        arst_n       = 1'b0;
        attack_valid = 1'b0;
        attack_req   = '0;
        rng          = 32'h79429501;
        pend_valid   = 1'b0;
        model_hp     = MAX_HP;
        model_alive  = 1'b1;
        repeat (3) @(posedge Clk);
        #2;
        arst_n = 1'b1;
        // Reset values
        check_hp(enemy_hp, MAX_HP);
        check_alive(enemy_alive, 1'b1);
        check_hit("hit_valid", hit_valid, 1'b0);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge Clk);
            #2;
            check_outputs();
            drive_attack();
        end
        if (kills == 0 || respawns == 0) begin
            report_failure("the enemy never died and came back during the run");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

//--- game_logic.f
rtl/game_pkg.sv
rtl/frame_tick.sv
rtl/attack_hit_detect.sv
rtl/enemy_health.sv
rtl/game_logic.sv
dv/game_logic_checker.sv
dv/tb_game_logic.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_game_logic -f game_logic.f

output=$(./obj_dir/Vtb_game_logic) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^Finished with no errors$"; then
    exit 0
else
    exit 1
fi
